//--- aes_accel.f
+incdir+logic
logic/aes_accel_pkg.sv
logic/aes_ctrl.sv
logic/aes_lane.sv
logic/aes_collect.sv
logic/aes_accel_top.sv
testbench/aes_accel_properties.sv
testbench/aes_accel_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f aes_accel.f --top-module aes_accel_tb -o aes_accel_sim

run: compile
	./obj_dir/aes_accel_sim 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/aes_accel_tb.sv
// ----------------------------------------------------------
// AES accelerator testbench
// Xorshift APB traffic checked against an AES-128 model.
// ----------------------------------------------------------
`include "aes_accel_macros.svh"

module aes_accel_tb;

  import aes_accel_pkg::*;

  localparam int N_BLOCKS = 1 + 40 + `AES_N_LANES + `AES_RES_DEPTH + 2 + 1;

  // Model S-box with entry 0 in the top byte.
  localparam logic [2047:0] REF_SBOX = {
    256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
    256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
    256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
    256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
    256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
    256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
    256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
    256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
  };

  logic        clk = 1'b0;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  aes_addr_t   paddr;
  aes_word_t   pwdata;
  aes_word_t   prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] rng;
  aes_key_t    cur_key;
  aes_block_t  exp_q [$];

  aes_accel_top aes_accel_top_inst (
    .clk_i     ( clk     ),
    .arst_n_i  ( arst_n  ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .prdata_o  ( prdata  ),
    .pready_o  ( pready  ),
    .pslverr_o ( pslverr )
  );

  always #4 clk = ~clk;

  function automatic aes_word_t next_word();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic aes_block_t next_block();
    aes_block_t b;
    for (int i = 0; i < 4; i++) begin
      b[127-32*i -: 32] = next_word();
    end
    return b;
  endfunction

  function automatic logic [7:0] sub_ref(input logic [7:0] b);
    return REF_SBOX[2047 - 8 * b -: 8];
  endfunction

  function automatic logic [7:0] dbl_ref(input logic [7:0] b);
    return (b << 1) ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Byte i of a block is row i%4, column i/4.
  function automatic aes_block_t ref_encrypt(input aes_key_t key, input aes_block_t pt);
    logic [7:0]  s [16];
    logic [7:0]  t [16];
    logic [31:0] w [4];
    logic [31:0] g;
    logic [7:0]  x;
    logic [7:0]  rc;
    aes_block_t  ct;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127-32*i -: 32];
    end
    for (int i = 0; i < 16; i++) begin
      s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];
    end
    for (int r = 1; r <= 10; r++) begin
      // SubBytes and ShiftRows in one pass.
      for (int i = 0; i < 16; i++) begin
        t[i] = sub_ref(s[(i + 4 * (i % 4)) % 16]);
      end
      // Column mix as a ^ sum ^ 2(a ^ next).
      for (int c = 0; c < 4; c++) begin
        x = t[4*c] ^ t[4*c+1] ^ t[4*c+2] ^ t[4*c+3];
        for (int k = 0; k < 4; k++) begin
          s[4*c+k] = (r == 10) ? t[4*c+k]
                               : t[4*c+k] ^ x ^ dbl_ref(t[4*c+k] ^ t[4*c+(k+1)%4]);
        end
      end
      g = {sub_ref(w[3][23:16]), sub_ref(w[3][15:8]),
           sub_ref(w[3][7:0]), sub_ref(w[3][31:24])};
      w[0] = w[0] ^ g ^ {rc, 24'h0};
      w[1] = w[1] ^ w[0];
      w[2] = w[2] ^ w[1];
      w[3] = w[3] ^ w[2];
      rc = dbl_ref(rc);
      for (int i = 0; i < 16; i++) begin
        s[i] = s[i] ^ w[i/4][31-8*(i%4) -: 8];
      end
    end
    for (int i = 0; i < 16; i++) begin
      ct[127-8*i -: 8] = s[i];
    end
    return ct;
  endfunction

  task automatic report_failure();
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_block(input string name, input aes_block_t got, input aes_block_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_word(input string name, input aes_word_t got, input aes_word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  // Response is sampled on the edge that completes the transfer.
  task automatic apb_xfer(input logic wr, input aes_addr_t addr, input aes_word_t wdata,
                          input logic exp_err, output aes_word_t rdata);
    @(posedge clk);
    psel   <= 1'b1;
    pwrite <= wr;
    paddr  <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    do begin
      @(posedge clk);
      // Only a DIN3 write may add wait states.
      if (!(wr && addr == `AES_REG_DIN3)) begin
        check_err("pready", pready, 1'b1);
      end
    end while (!pready);
    rdata = prdata;
    check_err("pslverr", pslverr, exp_err);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_status(output aes_word_t st);
    apb_xfer(1'b0, `AES_REG_STATUS, '0, 1'b0, st);
  endtask

  task automatic write_quad(input aes_addr_t base, input aes_block_t data);
    aes_word_t rd;
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b1, base + aes_addr_t'(4 * i), data[127-32*i -: 32], 1'b0, rd);
    end
  endtask

  task automatic load_key(input aes_key_t key);
    write_quad(`AES_REG_KEY0, key);
    cur_key = key;
  endtask

  // DIN3 stalls until the target lane takes the job.
  task automatic send_block(input aes_block_t pt);
    write_quad(`AES_REG_DIN0, pt);
    exp_q.push_back(ref_encrypt(cur_key, pt));
  endtask

  task automatic read_result();
    aes_block_t ct;
    aes_word_t  rd;
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b0, `AES_REG_DOUT0 + aes_addr_t'(4 * i), '0, 1'b0, rd);
      ct[127-32*i -: 32] = rd;
    end
    check_block("dout", ct, exp_q.pop_front());
  endtask

  task automatic drain_all();
    aes_word_t st;
    while (exp_q.size() > 0) begin
      read_status(st);
      if (st[0]) begin
        read_result();
      end
    end
  endtask

  // Watchdog sized from the block count.
  initial begin
    repeat (40 * N_BLOCKS + 2000) @(posedge clk);
    $display("Error at %0t: timeout, the DUT stopped responding", $time);
    report_failure();
  end

  initial begin
    aes_word_t  st;
    aes_word_t  rd;
    aes_block_t blk;
    arst_n  <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    rng     = 32'h3bd6_829f;
    cur_key = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    read_status(st);
    check_word("status", st, 32'h0);

    // FIPS-197 C.1 vector.
    blk = 128'h00112233445566778899aabbccddeeff;
    check_block("ref_encrypt", ref_encrypt(128'h000102030405060708090a0b0c0d0e0f, blk),
                128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    load_key(128'h000102030405060708090a0b0c0d0e0f);
    send_block(blk);
    drain_all();

    // Random stream with occasional key changes.
    for (int n = 0; n < 40; n++) begin
      blk = next_block();
      if (n == 0 || blk[0]) begin
        load_key(next_block());
      end
      send_block(blk);
      read_status(st);
      if (st[0]) begin
        read_result();
      end
    end
    drain_all();

    // Fill every lane and the FIFO.
    for (int n = 0; n < `AES_N_LANES + `AES_RES_DEPTH; n++) begin
      send_block(next_block());
    end
    do begin
      read_status(st);
    end while (st[7:4] != aes_count_t'(`AES_RES_DEPTH));
    check_word("status", st, aes_word_t'((`AES_RES_DEPTH << 4) | 3));
    // Each pop frees one lane for one more job.
    for (int n = 0; n < 2; n++) begin
      read_result();
      send_block(next_block());
    end
    drain_all();
    read_status(st);
    check_word("status", st, 32'h0);

    // Error responses.
    apb_xfer(1'b0, `AES_REG_DOUT3, '0, 1'b1, rd);
    apb_xfer(1'b1, `AES_REG_STATUS, 32'h1, 1'b1, rd);
    apb_xfer(1'b0, 8'h40, '0, 1'b1, rd);
    send_block(next_block());
    drain_all();
    read_status(st);
    check_word("status", st, 32'h0);

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- testbench/aes_accel_properties.sv
// ----------------------------------------------------------
// AES accelerator assertions
// APB response timing and internal handshake checks.
// ----------------------------------------------------------
`include "aes_accel_macros.svh"

module aes_accel_properties (
  input logic                                          clk_i,
  input logic                                          arst_n_i,
  input logic                                          psel_i,
  input logic                                          penable_i,
  input logic                                          pready_i,
  input logic                                          pslverr_i,
  input aes_accel_pkg::aes_result_t [`AES_N_LANES-1:0] res_i,
  input logic [`AES_N_LANES-1:0]                       res_valid_i,
  input logic [`AES_N_LANES-1:0]                       res_ready_i,
  input aes_accel_pkg::aes_count_t                     count_i
);

  import aes_accel_pkg::*;

  // No response outside the access phase.
  a_idle_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(psel_i && penable_i) |-> !pready_i && !pslverr_i)
    else $error("APB response outside an access phase");

  for (genvar g = 0; g < `AES_N_LANES; g++) begin : g_hold
    // A lane that waits keeps its result.
    a_res_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      res_valid_i[g] && !res_ready_i[g] |=> res_valid_i[g] && $stable(res_i[g]))
      else $error("lane %0d dropped or changed a pending result", g);
  end

  a_count_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_i <= aes_count_t'(`AES_RES_DEPTH))
    else $error("result FIFO count above its depth");

endmodule

bind aes_accel_top aes_accel_properties aes_accel_properties_inst (
  .clk_i       ( clk_i     ),
  .arst_n_i    ( arst_n_i  ),
  .psel_i      ( psel_i    ),
  .penable_i   ( penable_i ),
  .pready_i    ( pready_o  ),
  .pslverr_i   ( pslverr_o ),
  .res_i       ( res       ),
  .res_valid_i ( res_valid ),
  .res_ready_i ( res_ready ),
  .count_i     ( count     )
);

//--- logic/aes_accel_top.sv
// ----------------------------------------------------------
// AES-128 accelerator top level
// Control block, parallel encryption lanes and collector.
// ----------------------------------------------------------
`include "aes_accel_macros.svh"

module aes_accel_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // APB slave port
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  aes_accel_pkg::aes_addr_t paddr_i,
  input  aes_accel_pkg::aes_word_t pwdata_i,
  output aes_accel_pkg::aes_word_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o
);

  import aes_accel_pkg::*;

  aes_job_t                      job;
  logic [`AES_N_LANES-1:0]       job_valid;
  logic [`AES_N_LANES-1:0]       lane_ready;
  logic [`AES_N_LANES-1:0]       lane_busy;
  aes_result_t [`AES_N_LANES-1:0] res;
  logic [`AES_N_LANES-1:0]       res_valid;
  logic [`AES_N_LANES-1:0]       res_ready;
  aes_result_t                   head;
  logic                          head_valid;
  aes_count_t                    count;
  logic                          pop;
  logic                          busy;

  assign busy = |lane_busy;

  aes_ctrl i_ctrl (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .psel_i       ( psel_i     ),
    .penable_i    ( penable_i  ),
    .pwrite_i     ( pwrite_i   ),
    .paddr_i      ( paddr_i    ),
    .pwdata_i     ( pwdata_i   ),
    .prdata_o     ( prdata_o   ),
    .pready_o     ( pready_o   ),
    .pslverr_o    ( pslverr_o  ),
    .job_o        ( job        ),
    .job_valid_o  ( job_valid  ),
    .lane_ready_i ( lane_ready ),
    .head_i       ( head       ),
    .head_valid_i ( head_valid ),
    .count_i      ( count      ),
    .pop_o        ( pop        ),
    .busy_i       ( busy       )
  );

  // Encryption lanes share the job bus.
  for (genvar g = 0; g < `AES_N_LANES; g++) begin : g_lane
    aes_lane i_lane (
      .clk_i       ( clk_i         ),
      .arst_n_i    ( arst_n_i      ),
      .job_i       ( job           ),
      .job_valid_i ( job_valid[g]  ),
      .job_ready_o ( lane_ready[g] ),
      .res_o       ( res[g]        ),
      .res_valid_o ( res_valid[g]  ),
      .res_ready_i ( res_ready[g]  ),
      .busy_o      ( lane_busy[g]  )
    );
  end

  aes_collect i_collect (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .res_i        ( res        ),
    .res_valid_i  ( res_valid  ),
    .res_ready_o  ( res_ready  ),
    .head_o       ( head       ),
    .head_valid_o ( head_valid ),
    .count_o      ( count      ),
    .pop_i        ( pop        )
  );

endmodule

//--- logic/aes_collect.sv
// ----------------------------------------------------------
// AES result collector
// Drains lanes round-robin into an in-order result FIFO.
// ----------------------------------------------------------
`include "aes_accel_macros.svh"

module aes_collect (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,

  // Lane results
  input  aes_accel_pkg::aes_result_t [`AES_N_LANES-1:0] res_i,
  input  logic [`AES_N_LANES-1:0]                       res_valid_i,
  output logic [`AES_N_LANES-1:0]                       res_ready_o,

  // FIFO head toward the control block
  output aes_accel_pkg::aes_result_t                    head_o,
  output logic                                          head_valid_o,
  output aes_accel_pkg::aes_count_t                     count_o,
  input  logic                                          pop_i
);

  import aes_accel_pkg::*;

  localparam int unsigned FIFO_W = (`AES_RES_DEPTH > 1) ? $clog2(`AES_RES_DEPTH) : 1;

  aes_lane_idx_t     drain_q;
  logic [FIFO_W-1:0] wr_q;
  logic [FIFO_W-1:0] rd_q;
  aes_count_t        count_q;
  aes_result_t       mem_q [`AES_RES_DEPTH];
  logic              full;
  logic              accept;
  logic              do_pop;

  assign full = (count_q == aes_count_t'(`AES_RES_DEPTH));

  // Only the lane at the drain pointer sees ready.
  always_comb begin
    for (int i = 0; i < `AES_N_LANES; i++) begin
      res_ready_o[i] = !full && (drain_q == aes_lane_idx_t'(i));
    end
  end

  assign accept = res_valid_i[drain_q] & res_ready_o[drain_q];
  assign do_pop = pop_i & (count_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      drain_q <= '0;
      wr_q    <= '0;
      rd_q    <= '0;
      count_q <= '0;
    end else begin
      if (accept) begin
        drain_q <= (drain_q == aes_lane_idx_t'(`AES_N_LANES - 1)) ? '0 : drain_q + 1'b1;
        wr_q    <= (wr_q == FIFO_W'(`AES_RES_DEPTH - 1)) ? '0 : wr_q + 1'b1;
      end
      if (do_pop) begin
        rd_q <= (rd_q == FIFO_W'(`AES_RES_DEPTH - 1)) ? '0 : rd_q + 1'b1;
      end
      // Net occupancy change.
      if (accept && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !accept) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[wr_q] <= res_i[drain_q];
    end
  end

  assign head_o       = mem_q[rd_q];
  assign head_valid_o = (count_q != '0);
  assign count_o      = count_q;

endmodule

//--- logic/aes_lane.sv
// ----------------------------------------------------------
// AES-128 encryption lane
// Iterative core, one round per cycle, keys expanded on the fly.
// ----------------------------------------------------------
module aes_lane (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  // Job input
  input  aes_accel_pkg::aes_job_t    job_i,
  input  logic                       job_valid_i,
  output logic                       job_ready_o,

  // Result output
  output aes_accel_pkg::aes_result_t res_o,
  output logic                       res_valid_o,
  input  logic                       res_ready_i,

  output logic                       busy_o
);

  import aes_accel_pkg::*;

  aes_lane_state_e fsm_q;
  logic [3:0]      round_q;
  aes_byte_t       rcon_q;
  aes_block_t      state_q;
  aes_key_t        key_q;

  aes_word_t [0:3] kw;
  aes_word_t [0:3] nkw;
  aes_word_t       temp_w;
  aes_byte_t [0:15] st_b;
  aes_byte_t [0:15] sub_b;
  aes_byte_t [0:15] shf_b;
  aes_byte_t [0:15] mix_b;
  aes_block_t      round_out;
  logic            accept;
  logic            last_round;

  assign accept     = (fsm_q == LANE_IDLE) & job_valid_i;
  assign last_round = (round_q == 4'd10);

  // Next round key from the current one.
  always_comb begin
    kw     = key_q;
    temp_w = {aes_sbox(kw[3][23:16]), aes_sbox(kw[3][15:8]),
              aes_sbox(kw[3][7:0]), aes_sbox(kw[3][31:24])};
    temp_w = temp_w ^ {rcon_q, 24'h0};
    nkw[0] = kw[0] ^ temp_w;
    nkw[1] = kw[1] ^ nkw[0];
    nkw[2] = kw[2] ^ nkw[1];
    nkw[3] = kw[3] ^ nkw[2];
  end

  // SubBytes, ShiftRows, MixColumns. Byte 4c+r sits at row r, column c.
  always_comb begin
    st_b = state_q;
    for (int i = 0; i < 16; i++) begin
      sub_b[i] = aes_sbox(st_b[i]);
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shf_b[4*c+r] = sub_b[4*((c+r)%4)+r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mix_b[4*c]   = aes_xtime(shf_b[4*c]) ^ aes_xtime(shf_b[4*c+1]) ^ shf_b[4*c+1]
                     ^ shf_b[4*c+2] ^ shf_b[4*c+3];
      mix_b[4*c+1] = shf_b[4*c] ^ aes_xtime(shf_b[4*c+1]) ^ aes_xtime(shf_b[4*c+2])
                     ^ shf_b[4*c+2] ^ shf_b[4*c+3];
      mix_b[4*c+2] = shf_b[4*c] ^ shf_b[4*c+1] ^ aes_xtime(shf_b[4*c+2])
                     ^ aes_xtime(shf_b[4*c+3]) ^ shf_b[4*c+3];
      mix_b[4*c+3] = aes_xtime(shf_b[4*c]) ^ shf_b[4*c] ^ shf_b[4*c+1] ^ shf_b[4*c+2]
                     ^ aes_xtime(shf_b[4*c+3]);
    end
    // Final round skips MixColumns.
    round_out = last_round ? aes_block_t'(shf_b) : aes_block_t'(mix_b);
  end

  // Lane FSM and round counter.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fsm_q   <= LANE_IDLE;
      round_q <= '0;
    end else begin
      case (fsm_q)
        LANE_IDLE: begin
          if (job_valid_i) begin
            fsm_q   <= LANE_ROUND;
            round_q <= 4'd1;
          end
        end
        LANE_ROUND: begin
          if (last_round) begin
            fsm_q <= LANE_DONE;
          end else begin
            round_q <= round_q + 4'd1;
          end
        end
        LANE_DONE: begin
          if (res_ready_i) begin
            fsm_q <= LANE_IDLE;
          end
        end
        default: fsm_q <= LANE_IDLE;
      endcase
    end
  end

  // State, round key and round constant.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      state_q <= job_i.pt ^ job_i.key;
      key_q   <= job_i.key;
      rcon_q  <= 8'h01;
    end else if (fsm_q == LANE_ROUND) begin
      state_q <= round_out ^ aes_block_t'(nkw);
      key_q   <= nkw;
      rcon_q  <= aes_xtime(rcon_q);
    end
  end

  assign job_ready_o = (fsm_q == LANE_IDLE);
  assign res_valid_o = (fsm_q == LANE_DONE);
  assign res_o.ct    = state_q;
  assign busy_o      = (fsm_q != LANE_IDLE);

endmodule

//--- logic/aes_ctrl.sv
// ----------------------------------------------------------
// AES accelerator control block
// APB slave, register file and round-robin job dispatch.
// ----------------------------------------------------------
`include "aes_accel_macros.svh"

module aes_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // APB slave port
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  aes_accel_pkg::aes_addr_t  paddr_i,
  input  aes_accel_pkg::aes_word_t  pwdata_i,
  output aes_accel_pkg::aes_word_t  prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,

  // Job issue
  output aes_accel_pkg::aes_job_t   job_o,
  output logic [`AES_N_LANES-1:0]   job_valid_o,
  input  logic [`AES_N_LANES-1:0]   lane_ready_i,

  // Result side
  input  aes_accel_pkg::aes_result_t head_i,
  input  logic                      head_valid_i,
  input  aes_accel_pkg::aes_count_t count_i,
  output logic                      pop_o,
  input  logic                      busy_i
);

  import aes_accel_pkg::*;

  aes_word_t [0:3] key_q;
  aes_word_t [0:3] din_q;
  aes_lane_idx_t   issue_q;

  aes_word_t [0:3] head_words;
  aes_word_t       status_word;
  aes_word_t       rd_data;
  logic [1:0]      word_idx;
  logic            access;
  logic            key_hit;
  logic            din_hit;
  logic            dec_err;
  logic            din3_wr;
  logic            job_fire;
  logic            wr_done;

  assign access      = psel_i & penable_i;
  assign word_idx    = paddr_i[3:2];
  assign head_words  = head_i.ct;
  assign status_word = {24'h0, count_i, 2'b00, busy_i, head_valid_i};

  // Address decode and read mux.
  always_comb begin
    rd_data = '0;
    key_hit = 1'b0;
    din_hit = 1'b0;
    dec_err = 1'b0;
    case (paddr_i)
      `AES_REG_KEY0, `AES_REG_KEY1, `AES_REG_KEY2, `AES_REG_KEY3: begin
        key_hit = 1'b1;
        rd_data = key_q[word_idx];
      end
      `AES_REG_DIN0, `AES_REG_DIN1, `AES_REG_DIN2, `AES_REG_DIN3: begin
        din_hit = 1'b1;
        rd_data = din_q[word_idx];
      end
      `AES_REG_DOUT0, `AES_REG_DOUT1, `AES_REG_DOUT2, `AES_REG_DOUT3: begin
        rd_data = head_words[word_idx];
        // Read-only, and nothing to return when empty.
        dec_err = pwrite_i | ~head_valid_i;
      end
      `AES_REG_STATUS: begin
        rd_data = status_word;
        dec_err = pwrite_i;
      end
      default: dec_err = 1'b1;
    endcase
  end

  // DIN3 write launches a job to the lane at the issue pointer.
  assign din3_wr  = access & pwrite_i & (paddr_i == `AES_REG_DIN3);
  assign job_fire = din3_wr & lane_ready_i[issue_q];

  always_comb begin
    for (int i = 0; i < `AES_N_LANES; i++) begin
      job_valid_o[i] = din3_wr && (issue_q == aes_lane_idx_t'(i));
    end
  end

  assign job_o.key = key_q;
  assign job_o.pt  = {din_q[0], din_q[1], din_q[2], pwdata_i};

  // Stall the transfer until the target lane takes the job.
  assign pready_o  = access & (~din3_wr | job_fire);
  assign pslverr_o = pready_o & dec_err;
  assign prdata_o  = rd_data;
  assign wr_done   = pready_o & pwrite_i;

  assign pop_o = access & ~pwrite_i & (paddr_i == `AES_REG_DOUT3) & head_valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      key_q   <= '0;
      din_q   <= '0;
      issue_q <= '0;
    end else begin
      if (wr_done && key_hit) begin
        key_q[word_idx] <= pwdata_i;
      end
      if (wr_done && din_hit) begin
        din_q[word_idx] <= pwdata_i;
      end
      if (job_fire) begin
        if (issue_q == aes_lane_idx_t'(`AES_N_LANES - 1)) begin
          issue_q <= '0;
        end else begin
          issue_q <= issue_q + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/aes_accel_pkg.sv
// ----------------------------------------------------------
// AES accelerator package
// Shared types, lane states and byte-level AES helpers.
// ----------------------------------------------------------
`include "aes_accel_macros.svh"

package aes_accel_pkg;

  typedef logic [31:0]            aes_word_t;
  typedef logic [`AES_ADDR_W-1:0] aes_addr_t;
  typedef logic [127:0]           aes_block_t;
  typedef logic [127:0]           aes_key_t;
  typedef logic [7:0]             aes_byte_t;
  // Result FIFO occupancy, as shown in STATUS[7:4].
  typedef logic [3:0]             aes_count_t;

  localparam int unsigned AES_LANE_W = (`AES_N_LANES > 1) ? $clog2(`AES_N_LANES) : 1;
  typedef logic [AES_LANE_W-1:0]  aes_lane_idx_t;

  // One encryption request.
  typedef struct packed {
    aes_key_t   key;
    aes_block_t pt;
  } aes_job_t;

  // One finished ciphertext.
  typedef struct packed {
    aes_block_t ct;
  } aes_result_t;

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_ROUND,
    LANE_DONE
  } aes_lane_state_e;

  // Forward S-box, entry 0 in the top byte.
  localparam logic [0:255][7:0] AES_SBOX = {
    256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
    256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
    256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
    256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
    256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
    256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
    256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
    256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic aes_byte_t aes_sbox(input aes_byte_t b);
    return AES_SBOX[b];
  endfunction

  // Multiply by x in GF(2^8).
  function automatic aes_byte_t aes_xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

//--- logic/aes_accel_macros.svh
// ----------------------------------------------------------
// AES accelerator configuration
// Lane count, result FIFO depth and APB register map.
// ----------------------------------------------------------
`ifndef AES_ACCEL_MACROS_SVH
`define AES_ACCEL_MACROS_SVH

// Datapath sizing.
`define AES_N_LANES    4
`define AES_RES_DEPTH  4
`define AES_ADDR_W     8

// Register map. Word 0 holds the top 32 bits of a block.
`define AES_REG_KEY0   8'h00
`define AES_REG_KEY1   8'h04
`define AES_REG_KEY2   8'h08
`define AES_REG_KEY3   8'h0C
`define AES_REG_DIN0   8'h10
`define AES_REG_DIN1   8'h14
`define AES_REG_DIN2   8'h18
`define AES_REG_DIN3   8'h1C
`define AES_REG_DOUT0  8'h20
`define AES_REG_DOUT1  8'h24
`define AES_REG_DOUT2  8'h28
`define AES_REG_DOUT3  8'h2C
`define AES_REG_STATUS 8'h30

`endif
